//--- sim.f
source/fetch_pkg.sv
source/pc_gen.sv
source/axi_read_master.sv
source/fetch_queue.sv
source/inst_predecode.sv
source/fetch_top.sv
dv/axi_mem_model.sv
dv/fetch_checker.sv
dv/fetch_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= fetch_tb
FILELIST  ?= sim.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG) || ! grep -q "TEST OK" $(LOG); then \
		echo "simulation reported failure"; exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- dv/fetch_tb.sv
`timescale 1ns/1ns

module fetch_tb;
    import fetch_pkg::*;

    localparam logic [XLEN-1:0] RESET_PC = 32'h1000;
    localparam int CLK_PERIOD = 40;
    localparam int MAX_DLY    = 7;
    localparam int NUM_WORDS  = 16 + 24 + 20 + 24 + 12 + 14; // words consumed over all tests
    localparam int WATCHDOG_CYCLES = NUM_WORDS * (2 * MAX_DLY + 4) * 4;
    localparam logic [6:0] OPC_LUI = 7'b0110111; // not predecoded
    localparam logic [6:0] OPC_JAL = 7'b1101111;

    logic            clock = 1'b0;
    logic            reset;
    logic            run_i;
    logic            stall_i;
    logic            dec_valid;
    decoded_t        dec;
    logic            ar_valid;
    axi_ar_t         ar;
    logic            ar_ready;
    logic            r_valid;
    axi_r_t          r;
    logic            r_ready;

    logic [31:0]     prog [256];  // copy of the model memory
    logic [XLEN-1:0] err_addr;
    logic [XLEN-1:0] exp_pc;      // next decoded pc
    logic [XLEN-1:0] ar_exp;      // next AR address
    axi_ar_t         ar_attr;     // observed AR payload without its address
    int              ar_count;
    int              taken;
    int              err_seen;
    int              dec_errors   = 0;
    int              ar_errors    = 0;
    int              other_errors = 0;

    fetch_top #(.RESET_PC(RESET_PC), .QUEUE_DEPTH(4)) dut0 (
        .clock        (clock),
        .reset        (reset),
        .run_i        (run_i),
        .stall_i      (stall_i),
        .dec_valid_o  (dec_valid),
        .dec_o        (dec),
        .m_ar_valid_o (ar_valid),
        .m_ar_o       (ar),
        .m_ar_ready_i (ar_ready),
        .m_r_valid_i  (r_valid),
        .m_r_i        (r),
        .m_r_ready_o  (r_ready)
    );

    axi_mem_model mem0 (
        .clock      (clock),
        .reset      (reset),
        .ar_valid_i (ar_valid),
        .ar_i       (ar),
        .ar_ready_o (ar_ready),
        .r_valid_o  (r_valid),
        .r_o        (r),
        .r_ready_i  (r_ready)
    );

    always #(CLK_PERIOD / 2) clock = ~clock;

    task automatic compare_decoded(input string name, input decoded_t got, input decoded_t exp);
        if (got !== exp) begin
            dec_errors++;
            $display("[ERROR] %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic compare_ar_addr(input string name, input logic [XLEN-1:0] got,
                                   input logic [XLEN-1:0] exp);
        if (got !== exp) begin
            ar_errors++;
            $display("[ERROR] %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic compare_ar_attr(input string name, input axi_ar_t got, input axi_ar_t exp);
        if (got !== exp) begin
            ar_errors++;
            $display("[ERROR] %s got %h expected %h", name, got, exp);
        end
    endtask

    // attributes of a single-beat word read with the address left out
    function automatic axi_ar_t expect_ar_attr();
        axi_ar_t e;
        e       = '0;
        e.prot  = 3'b000;    // unprivileged secure data
        e.len   = 8'd0;      // one beat
        e.size  = 3'd2;      // four bytes per beat
        e.burst = 2'b01;     // incr
        e.cache = 4'b0010;   // normal non-cacheable non-bufferable
        return e;
    endfunction

    // expected decode from the rv32 field positions
    function automatic decoded_t expect_decode(input logic [XLEN-1:0] pc, input logic [31:0] w);
        decoded_t d;
        d     = '0;
        d.pc  = pc;
        d.err = (pc == err_addr);
        d.rd  = w[11:7];
        d.rs1 = w[19:15];
        if (w[6:0] == OPC_OP) begin
            d.kind = KIND_R;
            d.rs2  = w[24:20];
        end else if (w[6:0] == OPC_OP_IMM || w[6:0] == OPC_LOAD || w[6:0] == OPC_JALR) begin
            d.kind = KIND_I;
            d.imm  = {{20{w[31]}}, w[31:20]}; // sign extend imm12
        end else begin
            d.kind = KIND_OTHER;
            d.rs2  = w[24:20];
        end
        return d;
    endfunction

    function automatic logic [31:0] random_word();
        logic [31:0] v;
        v = $urandom;
        case (v[1:0])        // low bits pick the opcode and upper bits fill the fields
            2'd0:    return {v[31:7], OPC_OP};
            2'd1:    return {v[31:7], OPC_OP_IMM};
            2'd2:    return {v[31:7], (v[2] ? OPC_LOAD : OPC_JALR)};
            default: return {v[31:7], (v[3] ? OPC_LUI : OPC_JAL)};
        endcase
    endfunction

    // mode 0 fills an addi ladder keyed on the address and mode 1 random words
    task automatic start_fetch(input int mode, input int max_dly, input int err_idx);
        logic [XLEN-1:0] a;
        @(posedge clock);
        reset   <= 1'b0;
        run_i   <= 1'b0;
        stall_i <= 1'b0;
        for (int i = 0; i < 256; i++) begin
            a              = RESET_PC + 32'(i * 4);
            prog[i]        = (mode == 0) ? {a[13:2], a[6:2], 3'b000, a[11:7], OPC_OP_IMM}
                                         : random_word();
            mem0.mem[i]    = prog[i];
            mem0.ar_dly[i] = $urandom_range(max_dly, 0);
            mem0.r_dly[i]  = $urandom_range(max_dly, 0);
        end
        err_addr      = (err_idx < 0) ? 32'hffff_fff0 : RESET_PC + 32'(err_idx * 4);
        mem0.err_addr = err_addr;
        exp_pc        = RESET_PC;
        err_seen      = 0;
        repeat (3) @(posedge clock);
        reset <= 1'b1;
        @(posedge clock);
        run_i <= 1'b1;
    endtask

    // called at a falling edge so the item leaves on the next rising one
    task automatic take_output();
        if (dec_valid && !stall_i) begin
            compare_decoded("dec_o", dec, expect_decode(exp_pc, prog[exp_pc[9:2]]));
            if (dec.err) err_seen++;
            exp_pc = exp_pc + 32'd4;
            taken++;
        end
    endtask

    task automatic collect_stream(input int n, input int stall_cycles);
        int       start;
        decoded_t held;
        start = taken;
        while (taken - start < n) begin
            @(negedge clock);
            take_output();
            if (stall_cycles > 0 && taken - start == 2) begin
                @(posedge clock);
                stall_i <= 1'b1;
                do begin
                    @(negedge clock);
                end while (!dec_valid);
                held = dec;          // frozen from here on
                repeat (stall_cycles) begin
                    @(negedge clock);
                    compare_decoded("dec_o under stall", dec, held);
                end
                if (ar_valid) begin
                    other_errors++;
                    $display("queue is full but fetch still issues AR requests");
                end
                @(posedge clock);
                stall_i <= 1'b0;
                stall_cycles = 0;
            end
        end
    endtask

    task automatic sequential_fetch();
        start_fetch(0, 0, -1);
        collect_stream(16, 0);
    endtask

    task automatic decode_mix();
        start_fetch(1, 0, -1);
        collect_stream(24, 0);
    endtask

    task automatic stall_backpressure();
        start_fetch(1, 0, -1);
        collect_stream(20, 30);
    endtask

    task automatic slave_latency();
        start_fetch(1, MAX_DLY, -1);
        collect_stream(24, 0);
    endtask

    task automatic error_response();
        start_fetch(1, 2, 5);
        collect_stream(12, 0);
        if (err_seen != 1) begin
            other_errors++;
            $display("err flag seen on %0d entries, wanted exactly one", err_seen);
        end
    endtask

    task automatic stop_restart();
        int ar_before;
        start_fetch(1, 3, -1);
        collect_stream(6, 0);
        @(posedge clock);
        run_i <= 1'b0;
        ar_before = ar_count;
        repeat (60) begin    // let the pipeline drain
            @(negedge clock);
            take_output();
        end
        if (ar_count - ar_before > 1) begin
            other_errors++;
            $display("%0d AR requests after run_i dropped", ar_count - ar_before);
        end
        if (dec_valid) begin
            other_errors++;
            $display("decode output still busy after fetch was stopped");
        end
        @(posedge clock);
        run_i <= 1'b1;
        collect_stream(8, 0);
    endtask

    // every accepted AR must carry the next sequential pc
    always @(negedge clock) begin
        if (!reset) begin
            ar_exp   = RESET_PC;
            ar_count = 0;
        end else if (ar_valid && ar_ready) begin
            compare_ar_addr("m_ar_o.addr", ar.addr, ar_exp);
            ar_attr      = ar;
            ar_attr.addr = '0;
            compare_ar_attr("m_ar_o", ar_attr, expect_ar_attr());
            ar_exp = ar_exp + 32'd4;
            ar_count++;
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, fetch stream stuck", WATCHDOG_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        void'($urandom(32'h6e5a));
        reset   = 1'b0;
        run_i   = 1'b0;
        stall_i = 1'b0;
        taken   = 0;
        sequential_fetch();
        decode_mix();
        stall_backpressure();
        slave_latency();
        error_response();
        stop_restart();
        $display("errors: decode %0d, ar channel %0d, other %0d",
                 dec_errors, ar_errors, other_errors);
        if (dec_errors + ar_errors + other_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- dv/fetch_checker.sv
`timescale 1ns/1ns

module fetch_checker (
    input logic                clock,
    input logic                reset,
    input logic                stall_i,
    input logic                dec_valid_i,
    input fetch_pkg::decoded_t dec_i,
    input logic                ar_valid_i,
    input fetch_pkg::axi_ar_t  ar_i,
    input logic                ar_ready_i,
    input logic                r_ready_i
);

    // address channel holds until accepted
    ar_hold: assert property (@(posedge clock) disable iff (!reset)
        ar_valid_i && !ar_ready_i |=> ar_valid_i && $stable(ar_i))
        else $error("AR valid or payload changed before ar_ready");

    // one read at a time, the two phases never overlap
    ar_r_excl: assert property (@(posedge clock) disable iff (!reset)
        !(ar_valid_i && r_ready_i))
        else $error("r_ready high while ar_valid high");

    dec_hold: assert property (@(posedge clock) disable iff (!reset)
        stall_i && dec_valid_i |=> $stable(dec_i))
        else $error("dec_o changed while stalled");

endmodule

bind fetch_top fetch_checker checker0 (
    .clock       (clock),
    .reset       (reset),
    .stall_i     (stall_i),
    .dec_valid_i (dec_valid_o),
    .dec_i       (dec_o),
    .ar_valid_i  (m_ar_valid_o),
    .ar_i        (m_ar_o),
    .ar_ready_i  (m_ar_ready_i),
    .r_ready_i   (m_r_ready_o)
);

//--- dv/axi_mem_model.sv
`timescale 1ns/1ns

module axi_mem_model (
    input  logic               clock,
    input  logic               reset,
    input  logic               ar_valid_i,
    input  fetch_pkg::axi_ar_t ar_i,
    output logic               ar_ready_o,
    output logic               r_valid_o,
    output fetch_pkg::axi_r_t  r_o,
    input  logic               r_ready_i
);
    import fetch_pkg::*;

    localparam logic [1:0] RESP_SLVERR = 2'b10;
    localparam logic [1:0] S_AR        = 2'd0; // waiting out the ar delay
    localparam logic [1:0] S_ACC       = 2'd1; // ar_ready high, accept edge
    localparam logic [1:0] S_R         = 2'd2; // waiting out the r delay
    localparam logic [1:0] S_BEAT      = 2'd3; // r_valid high until ready

    logic [31:0]     mem    [256]; // word index from addr[9:2]
    int              ar_dly [256]; // cycles before ar_ready, per word
    int              r_dly  [256]; // cycles before r_valid, per word
    logic [XLEN-1:0] err_addr;     // this one answers with slverr
    logic [XLEN-1:0] addr_q;
    logic [1:0]      state;
    int              cnt;

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state      <= S_AR;
            ar_ready_o <= 1'b0;
            r_valid_o  <= 1'b0;
            r_o        <= '0;
            addr_q     <= '0;
            cnt        <= 0;
        end else begin
            case (state)
                S_AR: begin
                    if (ar_valid_i && cnt >= ar_dly[ar_i.addr[9:2]]) begin
                        ar_ready_o <= 1'b1;
                        cnt        <= 0;
                        state      <= S_ACC;
                    end else if (ar_valid_i) begin
                        cnt <= cnt + 1;
                    end
                end
                S_ACC: begin
                    ar_ready_o <= 1'b0;      // master holds valid, so handshake here
                    addr_q     <= ar_i.addr;
                    state      <= S_R;
                end
                S_R: begin
                    if (cnt >= r_dly[addr_q[9:2]]) begin
                        r_valid_o <= 1'b1;
                        r_o.data  <= mem[addr_q[9:2]];
                        r_o.resp  <= (addr_q == err_addr) ? RESP_SLVERR : AXI_RESP_OKAY;
                        r_o.last  <= 1'b1;   // always a single beat
                        r_o.id    <= '0;
                        cnt       <= 0;
                        state     <= S_BEAT;
                    end else begin
                        cnt <= cnt + 1;
                    end
                end
                default: begin
                    if (r_ready_i) begin
                        r_valid_o <= 1'b0;
                        state     <= S_AR;
                    end
                end
            endcase
        end
    end

endmodule

//--- source/fetch_top.sv
`timescale 1ns/1ns

module fetch_top #(
    parameter logic [fetch_pkg::XLEN-1:0] RESET_PC    = '0,
    parameter int                         QUEUE_DEPTH = 4
) (
    input  logic                clock,
    input  logic                reset,
    input  logic                run_i,
    input  logic                stall_i,
    output logic                dec_valid_o,
    output fetch_pkg::decoded_t dec_o,
    output logic                m_ar_valid_o,
    output fetch_pkg::axi_ar_t  m_ar_o,
    input  logic                m_ar_ready_i,
    input  logic                m_r_valid_i,
    input  fetch_pkg::axi_r_t   m_r_i,
    output logic                m_r_ready_o
);
    import fetch_pkg::*;

    logic            req_valid;
    logic [XLEN-1:0] req_addr;
    logic            rsp_valid;  // also the queue push
    fetch_entry_t    rsp;
    logic            space;
    fetch_entry_t    head;
    logic            not_empty;
    logic            pop;

    pc_gen #(.RESET_PC(RESET_PC)) pc_gen0 (
        .clock       (clock),
        .reset       (reset),
        .run_i       (run_i),
        .space_i     (space),
        .rsp_valid_i (rsp_valid),
        .req_valid_o (req_valid),
        .req_addr_o  (req_addr)
    );

    axi_read_master axi_read_master0 (
        .clock       (clock),
        .reset       (reset),
        .req_valid_i (req_valid),
        .req_addr_i  (req_addr),
        .rsp_valid_o (rsp_valid),
        .rsp_o       (rsp),
        .ar_valid_o  (m_ar_valid_o),
        .ar_o        (m_ar_o),
        .ar_ready_i  (m_ar_ready_i),
        .r_i         (m_r_i),
        .r_valid_i   (m_r_valid_i),
        .r_ready_o   (m_r_ready_o)
    );

    fetch_queue #(.QUEUE_DEPTH(QUEUE_DEPTH)) fetch_queue0 (
        .clock       (clock),
        .reset       (reset),
        .push_i      (rsp_valid),
        .push_data_i (rsp),
        .pop_i       (pop),
        .head_o      (head),
        .not_empty_o (not_empty),
        .space_o     (space)
    );

    inst_predecode inst_predecode0 (
        .clock       (clock),
        .reset       (reset),
        .not_empty_i (not_empty),
        .head_i      (head),
        .pop_o       (pop),
        .stall_i     (stall_i),
        .dec_valid_o (dec_valid_o),
        .dec_o       (dec_o)
    );

endmodule

//--- source/inst_predecode.sv
`timescale 1ns/1ns

module inst_predecode (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    not_empty_i,
    input  fetch_pkg::fetch_entry_t head_i,
    output logic                    pop_o,
    input  logic                    stall_i,
    output logic                    dec_valid_o,
    output fetch_pkg::decoded_t     dec_o
);
    import fetch_pkg::*;

    inst_u    word;
    decoded_t dec_next;

    // take a new entry when the output slot is free or moving
    assign pop_o = not_empty_i & (~dec_valid_o | ~stall_i);

    always_comb begin
        word         = head_i.inst;
        dec_next     = '0;
        dec_next.pc  = head_i.pc;     // passes through
        dec_next.err = head_i.err;
        dec_next.rd  = word.r_view.rd;
        dec_next.rs1 = word.r_view.rs1;
        case (word.r_view.opcode)
            OPC_OP: begin
                dec_next.kind = KIND_R;
                dec_next.rs2  = word.r_view.rs2;
            end
            OPC_OP_IMM, OPC_LOAD, OPC_JALR: begin
                dec_next.kind = KIND_I;
                dec_next.imm  = {{20{word.i_view.imm12[11]}}, word.i_view.imm12};
            end
            default: begin
                dec_next.kind = KIND_OTHER;
                dec_next.rs2  = word.r_view.rs2; // raw fields, imm stays zero
            end
        endcase
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            dec_valid_o <= 1'b0;
        end else if (pop_o) begin
            dec_valid_o <= 1'b1;
        end else if (!stall_i) begin
            dec_valid_o <= 1'b0;   // consumed, nothing behind it
        end
    end

    always_ff @(posedge clock) begin
        if (pop_o) dec_o <= dec_next; // held otherwise
    end

endmodule

//--- source/fetch_queue.sv
`timescale 1ns/1ns

module fetch_queue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                    clock,
    input  logic                    reset,
    input  logic                    push_i,
    input  fetch_pkg::fetch_entry_t push_data_i,
    input  logic                    pop_i,
    output fetch_pkg::fetch_entry_t head_o,
    output logic                    not_empty_o,
    output logic                    space_o      // room after a same-cycle push
);
    import fetch_pkg::*;

    localparam int PTR_W = $clog2(QUEUE_DEPTH);
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    fetch_entry_t     mem [QUEUE_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_push;
    logic             do_pop;

    // wrap for depths that are not a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : p + PTR_W'(1);
    endfunction

    assign do_pop  = pop_i & not_empty_o;
    assign do_push = push_i & ((count != CNT_W'(QUEUE_DEPTH)) | do_pop); // full only if no pop

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= ptr_inc(wr_ptr);
            if (do_pop)  rd_ptr <= ptr_inc(rd_ptr);
            case ({do_push, do_pop})
                2'b10:   count <= count + CNT_W'(1);
                2'b01:   count <= count - CNT_W'(1);
                default: count <= count;          // both or neither
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (do_push) mem[wr_ptr] <= push_data_i;
    end

    assign head_o      = mem[rd_ptr];
    assign not_empty_o = (count != '0);
    // count + incoming push still below depth
    assign space_o     = ({1'b0, count} + {{CNT_W{1'b0}}, push_i}) < (CNT_W + 1)'(QUEUE_DEPTH);

endmodule

//--- source/axi_read_master.sv
`timescale 1ns/1ns

module axi_read_master (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       req_valid_i,
    input  logic [fetch_pkg::XLEN-1:0] req_addr_i,
    output logic                       rsp_valid_o,  // one-cycle pulse
    output fetch_pkg::fetch_entry_t    rsp_o,
    output logic                       ar_valid_o,
    output fetch_pkg::axi_ar_t         ar_o,
    input  logic                       ar_ready_i,
    input  fetch_pkg::axi_r_t          r_i,
    input  logic                       r_valid_i,
    output logic                       r_ready_o
);
    import fetch_pkg::*;

    // read fsm encoding
    localparam logic [1:0] ST_IDLE    = 2'b00;
    localparam logic [1:0] ST_AR_WAIT = 2'b01;
    localparam logic [1:0] ST_R_WAIT  = 2'b11;

    // bytes per beat as log2
    localparam logic [2:0] AR_SIZE = 3'($clog2(AXI_DATA_W / 8));

    logic [1:0]      state;
    logic [1:0]      state_next;
    logic [XLEN-1:0] addr_q;     // address of the read in flight
    logic            ar_hs;
    logic            r_hs;

    assign ar_hs = ar_valid_o & ar_ready_i;
    assign r_hs  = r_valid_i & r_ready_o;

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state <= ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE:    if (req_valid_i) state_next = ST_AR_WAIT;
            ST_AR_WAIT: if (ar_ready_i)  state_next = ST_R_WAIT;  // address accepted
            ST_R_WAIT:  if (r_valid_i)   state_next = ST_IDLE;    // single beat done
            default:    state_next = ST_IDLE;
        endcase
    end

    assign ar_valid_o = (state == ST_AR_WAIT); // held until ready
    assign r_ready_o  = (state == ST_R_WAIT);

    // ar payload, only addr moves
    always_comb begin
        ar_o       = '0;
        ar_o.addr  = req_addr_i;     // stable while pc_gen waits
        ar_o.prot  = AXI_PROT_DATA;
        ar_o.id    = '0;
        ar_o.len   = 8'd0;           // one beat
        ar_o.size  = AR_SIZE;
        ar_o.burst = AXI_BURST_INCR;
        ar_o.cache = AXI_CACHE_NC;
    end

    always_ff @(posedge clock) begin
        if (ar_hs) begin
            addr_q <= ar_o.addr;
        end
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            rsp_valid_o <= 1'b0;
        end else begin
            rsp_valid_o <= r_hs;
        end
    end

    // response payload, taken on the r handshake edge
    always_ff @(posedge clock) begin
        if (r_hs) begin
            rsp_o.pc   <= addr_q;
            rsp_o.inst <= r_i.data;
            rsp_o.err  <= (r_i.resp != AXI_RESP_OKAY); // slverr or decerr
        end
    end

endmodule

//--- source/pc_gen.sv
`timescale 1ns/1ns

module pc_gen #(
    parameter logic [fetch_pkg::XLEN-1:0] RESET_PC = '0
) (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       run_i,       // fetch enable
    input  logic                       space_i,     // queue can take one more
    input  logic                       rsp_valid_i, // one fetch completed
    output logic                       req_valid_o,
    output logic [fetch_pkg::XLEN-1:0] req_addr_o
);
    import fetch_pkg::*;

    logic [XLEN-1:0] pc;

    // step on each completion only
    // address stays put while a read is outstanding
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            pc <= RESET_PC;
        end else if (rsp_valid_i) begin
            pc <= pc + XLEN'(4); // next word
        end
    end

    // level request, throttled by the queue
    // may stay high through the completion pulse, next AR then sees new pc
    assign req_valid_o = run_i & space_i;
    assign req_addr_o  = pc;

endmodule

//--- source/fetch_pkg.sv
package fetch_pkg;

    localparam int XLEN       = 32; // fetch address width
    localparam int AXI_ID_W   = 4;
    localparam int AXI_DATA_W = 32; // one instruction per beat

    // axi read-side encodings
    localparam logic [1:0] AXI_RESP_OKAY  = 2'b00;
    localparam logic [1:0] AXI_BURST_INCR = 2'b01;
    localparam logic [2:0] AXI_PROT_DATA  = 3'b000; // unprivileged, secure, data
    localparam logic [3:0] AXI_CACHE_NC   = 4'b0010; // normal non-cacheable non-bufferable

    // rv32 major opcodes seen by the predecoder
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    typedef struct packed {
        logic [XLEN-1:0]     addr;
        logic [2:0]          prot;
        logic [AXI_ID_W-1:0] id;
        logic [7:0]          len;   // beats minus one
        logic [2:0]          size;
        logic [1:0]          burst;
        logic [3:0]          cache;
    } axi_ar_t;

    typedef struct packed {
        logic [AXI_DATA_W-1:0] data;
        logic [1:0]            resp;
        logic                  last;
        logic [AXI_ID_W-1:0]   id;
    } axi_r_t;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [31:0]     inst;
        logic            err;   // resp was not okay
    } fetch_entry_t;

    // same word, two field layouts
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r_view;
        struct packed {
            logic [11:0] imm12;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i_view;
    } inst_u;

    typedef enum logic [1:0] {
        KIND_R,
        KIND_I,
        KIND_OTHER
    } inst_kind_e;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        inst_kind_e      kind;
        logic [4:0]      rd;
        logic [4:0]      rs1;
        logic [4:0]      rs2;
        logic [31:0]     imm;   // sign extended
        logic            err;
    } decoded_t;

endpackage
